//--- build.f
+incdir+include
hw/icache_pkg.sv
hw/icache_store.sv
hw/icache_refill.sv
hw/icache_ctrl.sv
hw/icache_top.sv
tb/icache_asserts.sv
tb/tb_icache.sv

//--- run.sh
#!/bin/sh
# compile and run the icache testbench with Verilator
set -e

rm -rf obj_dir sim.log

verilator --binary --timing --assert -f build.f --top-module tb_icache -o tb_icache

./obj_dir/tb_icache > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation PASSED" sim.log; then
    exit 0
else
    exit 1
fi

//--- tb/tb_icache.sv
`timescale 1ns/100ps
`include "icache_macros.svh"

module tb_icache;
    import icache_pkg::*;

    // op budget covers all directed tests plus the random mix
    localparam int N_OPS   = 220;
    localparam int TIMEOUT = N_OPS * 40 + 40;

    logic                      clk;
    logic                      rstn;
    icache_op_t                op;
    logic [`ICACHE_ADDR_W-1:0] addr;
    logic                      cached;
    logic                      ready;
    logic                      ins_valid;
    logic [`ICACHE_DATA_W-1:0] ins;
    logic                      mem_req_valid;
    logic [`ICACHE_ADDR_W-1:0] mem_req_addr;
    logic                      mem_req_block;
    logic                      mem_credit = 1'b0;
    logic                      mem_rsp_valid = 1'b0;
    logic [`ICACHE_DATA_W-1:0] mem_rsp_data = '0;

    int                        cycle = 0;
    // separate lfsr states for stimulus and memory timing
    logic [31:0]               lfsr_stim;
    logic [31:0]               lfsr_mem;
    bit                        hold_credits;

    // shadow of the tag array
    bit                        sh_valid [`ICACHE_LINES];
    logic [`ICACHE_TAG_W-1:0]  sh_tag [`ICACHE_LINES];

    // expected responses and requests
    logic [31:0]               exp_ins_q[$];
    bit                        exp_hit_q[$];
    int                        exp_cyc_q[$];
    logic [31:0]               req_addr_q[$];
    bit                        req_blk_q[$];

    // memory model state
    logic [31:0]               beat_q[$];
    int                        rsp_wait;
    int                        credit_due_q[$];
    logic [31:0]               exp_word;
    bit                        exp_hit;
    int                        exp_cyc;

    icache_top dut0 (
        .clk(clk), .rstn(rstn),
        .op(op), .addr(addr), .cached(cached),
        .ready(ready), .ins_valid(ins_valid), .ins(ins),
        .mem_req_valid(mem_req_valid), .mem_req_addr(mem_req_addr),
        .mem_req_block(mem_req_block), .mem_credit(mem_credit),
        .mem_rsp_valid(mem_rsp_valid), .mem_rsp_data(mem_rsp_data)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Simulation FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("** Error: %s got 0x%h expected 0x%h", name, got, exp);
            $display("Simulation FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    // fibonacci lfsr with taps 32 22 2 1 stepped once per bit
    function automatic int unsigned rand_bits(inout logic [31:0] s, input int n);
        int unsigned r;
        logic        fb;
        r = 0;
        for (int i = 0; i < n; i++) begin
            fb = s[31] ^ s[21] ^ s[1] ^ s[0];
            s  = {s[30:0], fb};
            r  = (r << 1) | 32'(fb);
        end
        return r;
    endfunction

    // memory contents as the word address rotated and scrambled
    function automatic logic [31:0] mem_word(input logic [31:0] a);
        logic [31:0] wa;
        wa = a >> 2;
        return {wa[24:0], wa[31:25]} ^ 32'h5a3c96e1;
    endfunction

    // reference model of one accepted op
    task automatic predict(input icache_op_t o, input logic [31:0] a, input logic c);
        logic [5:0]  idx;
        logic [20:0] tag;
        bit          h;
        idx = a[10:5];
        tag = a[31:11];
        h   = sh_valid[idx] && (sh_tag[idx] == tag);
        case (o)
            op_load: begin
                exp_ins_q.push_back(mem_word(a));
                exp_hit_q.push_back(c && h);
                exp_cyc_q.push_back(cycle);
                if (!c) begin
                    // uncached loads read one beat and never allocate
                    req_addr_q.push_back(a);
                    req_blk_q.push_back(1'b0);
                end else if (!h) begin
                    req_addr_q.push_back({a[31:5], 5'd0});
                    req_blk_q.push_back(1'b1);
                    sh_valid[idx] = 1'b1;
                    sh_tag[idx]   = tag;
                end
            end
            op_init, op_index_inv: begin
                sh_valid[idx] = 1'b0;
            end
            op_hit_inv: begin
                if (h) begin
                    sh_valid[idx] = 1'b0;
                end
            end
            default: begin
            end
        endcase
    endtask

    // present an op on a falling edge once ready is seen
    task automatic issue(input icache_op_t o, input logic [31:0] a, input logic c);
        while (ready !== 1'b1) begin
            op = op_none;
            @(negedge clk);
        end
        op     = o;
        addr   = a;
        cached = c;
        predict(o, a, c);
        @(negedge clk);
        op = op_none;
    endtask

    // wait until everything outstanding is answered
    task automatic drain(input bit wait_credits);
        while (exp_ins_q.size() != 0 || ready !== 1'b1 || beat_q.size() != 0 ||
               (wait_credits && credit_due_q.size() != 0)) begin
            @(negedge clk);
        end
        if (req_addr_q.size() != 0) begin
            report_failure("an expected memory request never appeared");
        end
    endtask

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle > TIMEOUT) begin
            $display("timeout, the run did not finish in %0d cycles", TIMEOUT);
            $display("Simulation FAILED");
            $fatal(1, "timeout");
        end
    end

    // compare outputs and play the memory on the falling edge
    always @(negedge clk) begin
        if (rstn) begin
            if (ins_valid) begin
                if (exp_ins_q.size() == 0) begin
                    report_failure("ins_valid rose with no load outstanding");
                end
                exp_word = exp_ins_q.pop_front();
                exp_hit  = exp_hit_q.pop_front();
                exp_cyc  = exp_cyc_q.pop_front();
                check("ins", ins, exp_word);
                if (exp_hit && cycle != exp_cyc + 1) begin
                    report_failure("a cache hit did not return one cycle after acceptance");
                end
            end
            if (mem_req_valid) begin
                if (req_addr_q.size() == 0) begin
                    report_failure("a memory request appeared that the model did not expect");
                end
                check("mem_req_addr", mem_req_addr, req_addr_q.pop_front());
                check("mem_req_block", 32'(mem_req_block), 32'(req_blk_q.pop_front()));
                rsp_wait = 1 + int'(rand_bits(lfsr_mem, 2));
                for (int i = 0; i < (mem_req_block ? 8 : 1); i++) begin
                    beat_q.push_back(mem_word(mem_req_addr + 32'(4 * i)));
                end
                credit_due_q.push_back(cycle + 1 + int'(rand_bits(lfsr_mem, 3)));
            end
        end
        mem_rsp_valid = 1'b0;
        mem_credit    = 1'b0;
        if (beat_q.size() != 0) begin
            if (rsp_wait > 0) begin
                rsp_wait = rsp_wait - 1;
            end else begin
                mem_rsp_valid = 1'b1;
                mem_rsp_data  = beat_q.pop_front();
            end
        end
        // one credit back per cycle unless held
        if (!hold_credits && credit_due_q.size() != 0 && credit_due_q[0] <= cycle) begin
            void'(credit_due_q.pop_front());
            mem_credit = 1'b1;
        end
    end

    initial begin
        logic [2:0]  sel;
        logic [20:0] rtag;
        logic [5:0]  ridx;
        logic [31:0] ra;
        op           = op_none;
        addr         = '0;
        cached       = 1'b0;
        rstn         = 1'b0;
        hold_credits = 1'b0;
        lfsr_stim    = 32'ha4117db1;
        lfsr_mem     = 32'ha4117db1;
        rsp_wait     = 0;
        for (int i = 0; i < `ICACHE_LINES; i++) begin
            sh_valid[i] = 1'b0;
            sh_tag[i]   = '0;
        end
        repeat (5) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);
        check("ready", 32'(ready), 32'd1);
        check("ins_valid", 32'(ins_valid), 32'd0);
        check("mem_req_valid", 32'(mem_req_valid), 32'd0);

        // cold cached load reads one line
        issue(op_load, 32'h0001_2344, 1'b1);
        drain(1'b1);

        // back to back hits on the same line
        issue(op_load, 32'h0001_2340, 1'b1);
        issue(op_load, 32'h0001_2348, 1'b1);
        issue(op_load, 32'h0001_235c, 1'b1);
        drain(1'b1);

        // uncached word and then a cached miss on the same address
        issue(op_load, 32'h0002_0464, 1'b0);
        drain(1'b1);
        issue(op_load, 32'h0002_0464, 1'b1);
        drain(1'b1);

        // invalidates and init
        issue(op_index_inv, 32'h0001_2340, 1'b1);
        issue(op_load, 32'h0001_2344, 1'b1);
        drain(1'b1);
        issue(op_init, 32'h0001_2340, 1'b1);
        issue(op_load, 32'h0001_2350, 1'b1);
        drain(1'b1);
        // hit invalidate with another tag keeps the line
        issue(op_hit_inv, 32'h0001_2b40, 1'b1);
        issue(op_load, 32'h0001_2354, 1'b1);
        drain(1'b1);

        // use up both credits while memory keeps them
        hold_credits = 1'b1;
        issue(op_load, 32'h0003_0180, 1'b1);
        drain(1'b0);
        issue(op_load, 32'h0003_01c4, 1'b0);
        drain(1'b0);
        issue(op_load, 32'h0004_0208, 1'b1);
        repeat (20) begin
            check("ready", 32'(ready), 32'd0);
            check("mem_req_valid", 32'(mem_req_valid), 32'd0);
            @(negedge clk);
        end
        hold_credits = 1'b0;
        drain(1'b1);

        // random mix over three lines and two tags
        for (int n = 0; n < 200; n++) begin
            sel  = 3'(rand_bits(lfsr_stim, 3));
            rtag = rand_bits(lfsr_stim, 1) != 0 ? 21'h00a5c : 21'h01337;
            ridx = 6'(3 + rand_bits(lfsr_stim, 2) % 3);
            ra   = {rtag, ridx, 3'(rand_bits(lfsr_stim, 3)), 2'b00};
            case (sel)
                3'd4: issue(op_load, ra, 1'b0);
                3'd5: issue(op_init, ra, 1'b1);
                3'd6: issue(op_hit_inv, ra, 1'b1);
                3'd7: issue(op_index_inv, ra, 1'b1);
                default: issue(op_load, ra, 1'b1);
            endcase
            if (rand_bits(lfsr_stim, 2) == 0) begin
                @(negedge clk);
            end
        end
        drain(1'b1);

        $display("Simulation PASSED");
        $finish;
    end

endmodule

//--- tb/icache_asserts.sv
`timescale 1ns/100ps
`include "icache_macros.svh"

module icache_asserts (
    input logic                        clk,
    input logic                        rstn,
    input logic                        mem_req_valid,
    input logic                        mem_credit,
    input logic [`ICACHE_CREDIT_W-1:0] credit_cnt
);

    // credits as seen on the memory ports
    int credits_left;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            credits_left <= `ICACHE_MEM_CREDITS;
        end else begin
            credits_left <= credits_left - int'(mem_req_valid) + int'(mem_credit);
        end
    end

    // a request always spends a credit that memory has granted
    a_req_has_credit: assert property (
        @(posedge clk) disable iff (!rstn)
        mem_req_valid |-> (credits_left > 0)
    ) else $error("request issued with no credit left");

    // memory never returns more than it granted
    a_credit_bound: assert property (
        @(posedge clk) disable iff (!rstn)
        credit_cnt <= `ICACHE_CREDIT_W'(`ICACHE_MEM_CREDITS)
    ) else $error("credit count above the grant");

    // quiet and fully credited right out of reset
    a_reset_state: assert property (
        @(posedge clk)
        $rose(rstn) |-> (!mem_req_valid &&
                         credit_cnt == `ICACHE_CREDIT_W'(`ICACHE_MEM_CREDITS))
    ) else $error("refill engine not idle after reset");

endmodule

bind icache_refill icache_asserts asrt0 (
    .clk(clk),
    .rstn(rstn),
    .mem_req_valid(mem_req_valid),
    .mem_credit(mem_credit),
    .credit_cnt(credit_cnt)
);

//--- hw/icache_top.sv
`timescale 1ns/100ps
`include "icache_macros.svh"

module icache_top (
    input  logic                       clk,
    input  logic                       rstn,
    input  icache_pkg::icache_op_t     op,
    input  logic [`ICACHE_ADDR_W-1:0]  addr,
    input  logic                       cached,
    output logic                       ready,
    output logic                       ins_valid,
    output logic [`ICACHE_DATA_W-1:0]  ins,
    output logic                       mem_req_valid,
    output logic [`ICACHE_ADDR_W-1:0]  mem_req_addr,
    output logic                       mem_req_block,
    input  logic                       mem_credit,
    input  logic                       mem_rsp_valid,
    input  logic [`ICACHE_DATA_W-1:0]  mem_rsp_data
);
    import icache_pkg::*;

    // controller to store
    icache_addr_t              rd_addr;
    logic                      fill_en;
    logic                      inv_en;
    logic                      inv_clear_tag;
    logic                      hit_check;
    logic                      hit;
    logic [`ICACHE_DATA_W-1:0] rd_word;

    // controller to refill engine
    logic                      fetch_start;
    icache_addr_t              fetch_addr;
    logic                      fetch_block;
    logic                      fetch_done;
    logic [`ICACHE_DATA_W-1:0] fetch_word;

    // refilled line into the store
    logic [`ICACHE_LINE_W-1:0] line_data;

    icache_ctrl ctrl0 (
        .clk(clk), .rstn(rstn),
        .op(op), .addr(addr), .cached(cached),
        .ready(ready), .ins_valid(ins_valid), .ins(ins),
        .rd_addr(rd_addr), .fill_en(fill_en), .inv_en(inv_en),
        .inv_clear_tag(inv_clear_tag), .hit_check(hit_check),
        .hit(hit), .rd_word(rd_word),
        .fetch_start(fetch_start), .fetch_addr(fetch_addr), .fetch_block(fetch_block),
        .fetch_done(fetch_done), .fetch_word(fetch_word)
    );

    icache_store store0 (
        .clk(clk), .rstn(rstn),
        .rd_addr(rd_addr), .fill_en(fill_en), .line_data(line_data),
        .inv_en(inv_en), .inv_clear_tag(inv_clear_tag), .hit_check(hit_check),
        .hit(hit), .rd_word(rd_word)
    );

    icache_refill refill0 (
        .clk(clk), .rstn(rstn),
        .fetch_start(fetch_start), .fetch_addr(fetch_addr), .fetch_block(fetch_block),
        .fetch_done(fetch_done), .fetch_word(fetch_word), .line_data(line_data),
        .mem_req_valid(mem_req_valid), .mem_req_addr(mem_req_addr),
        .mem_req_block(mem_req_block), .mem_credit(mem_credit),
        .mem_rsp_valid(mem_rsp_valid), .mem_rsp_data(mem_rsp_data)
    );

endmodule

//--- hw/icache_ctrl.sv
`timescale 1ns/100ps
`include "icache_macros.svh"

module icache_ctrl (
    input  logic                       clk,
    input  logic                       rstn,
    input  icache_pkg::icache_op_t     op,
    input  logic [`ICACHE_ADDR_W-1:0]  addr,
    input  logic                       cached,
    output logic                       ready,
    output logic                       ins_valid,
    output logic [`ICACHE_DATA_W-1:0]  ins,
    output icache_pkg::icache_addr_t   rd_addr,
    output logic                       fill_en,
    output logic                       inv_en,
    output logic                       inv_clear_tag,
    output logic                       hit_check,
    input  logic                       hit,
    input  logic [`ICACHE_DATA_W-1:0]  rd_word,
    output logic                       fetch_start,
    output icache_pkg::icache_addr_t   fetch_addr,
    output logic                       fetch_block,
    input  logic                       fetch_done,
    input  logic [`ICACHE_DATA_W-1:0]  fetch_word
);
    import icache_pkg::*;

    icache_state_t            state;
    icache_state_t            state_nx;
    icache_op_t               req_op;
    logic [`ICACHE_ADDR_W-1:0] req_addr;
    logic                     accept;

    // first state after an operation is taken
    function automatic icache_state_t accept_state(input icache_op_t o, input logic c);
        icache_state_t s;
        case (o)
            op_load: begin
                // uncached loads bypass the arrays
                s = c ? st_lookup : st_req_word;
            end
            op_hit_inv: begin
                s = st_hit_inv;
            end
            // init shares the index write path
            op_init, op_index_inv: begin
                s = st_index_wv;
            end
            default: begin
                s = st_idle;
            end
        endcase
        return s;
    endfunction

    // ready in lookup only on a hit, a miss stops the pipe
    always_comb begin
        case (state)
            st_idle: begin
                ready = 1'b1;
            end
            st_lookup: begin
                ready = hit;
            end
            default: begin
                ready = 1'b0;
            end
        endcase
    end

    assign accept = ready && (op != op_none);

    always_comb begin
        state_nx = state;
        unique case (state)
            st_idle: begin
                state_nx = accept ? accept_state(op, cached) : st_idle;
            end
            st_lookup: begin
                if (!hit) begin
                    state_nx = st_req_block;
                end else begin
                    state_nx = accept ? accept_state(op, cached) : st_idle;
                end
            end
            st_req_word: begin
                state_nx = st_word_wait;
            end
            st_word_wait: begin
                state_nx = fetch_done ? st_idle : st_word_wait;
            end
            st_req_block: begin
                state_nx = st_block_wait;
            end
            st_block_wait: begin
                state_nx = fetch_done ? st_fill : st_block_wait;
            end
            // written line is looked up once more
            st_fill: begin
                state_nx = st_lookup;
            end
            st_hit_inv, st_index_wv: begin
                state_nx = st_idle;
            end
            default: begin
                state_nx = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state  <= st_idle;
            req_op <= op_none;
        end else begin
            state <= state_nx;
            if (accept) begin
                req_op <= op;
            end
        end
    end

    // held address for refill, fill and invalidate
    always_ff @(posedge clk) begin
        if (accept) begin
            req_addr <= addr;
        end
    end

    // new address while taking ops, else keep the held one in the store
    assign rd_addr = ready ? addr : req_addr;

    // store side
    assign fill_en       = (state == st_fill);
    assign inv_en        = (state == st_hit_inv) || (state == st_index_wv);
    assign hit_check     = (state == st_hit_inv);
    assign inv_clear_tag = (state == st_index_wv) && (req_op == op_init);

    // refill side, one pulse per fetch
    assign fetch_start = (state == st_req_word) || (state == st_req_block);
    assign fetch_block = (state == st_req_block);
    assign fetch_addr  = req_addr;

    // cpu side
    assign ins_valid = ((state == st_lookup) && hit) ||
                       ((state == st_word_wait) && fetch_done);
    assign ins = (state == st_word_wait) ? fetch_word : rd_word;

endmodule

//--- hw/icache_refill.sv
`timescale 1ns/100ps
`include "icache_macros.svh"

module icache_refill (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       fetch_start,
    input  icache_pkg::icache_addr_t   fetch_addr,
    input  logic                       fetch_block,
    output logic                       fetch_done,
    output logic [`ICACHE_DATA_W-1:0]  fetch_word,
    output logic [`ICACHE_LINE_W-1:0]  line_data,
    output logic                       mem_req_valid,
    output logic [`ICACHE_ADDR_W-1:0]  mem_req_addr,
    output logic                       mem_req_block,
    input  logic                       mem_credit,
    input  logic                       mem_rsp_valid,
    input  logic [`ICACHE_DATA_W-1:0]  mem_rsp_data
);
    import icache_pkg::*;

    logic [`ICACHE_CREDIT_W-1:0] credit_cnt;
    logic                        pending;
    logic                        block_q;
    logic                        done_q;
    icache_addr_t                aligned;
    logic [`ICACHE_ADDR_W-1:0]   req_addr_q;
    logic [`ICACHE_WOFF_W-1:0]   beat_cnt;
    logic [`ICACHE_LINE_W-1:0]   line_buf;
    logic                        send;
    logic                        last_beat;

    // block reads start at the line boundary
    always_comb begin
        aligned = fetch_addr;
        if (fetch_block) begin
            aligned.refill.off = '0;
        end
    end

    // request goes out only while memory has granted room
    assign send          = pending && (credit_cnt != '0);
    assign mem_req_valid = send;
    assign mem_req_addr  = req_addr_q;
    assign mem_req_block = block_q;

    // one beat for a word, eight for a line
    assign last_beat = !block_q || (beat_cnt == `ICACHE_WOFF_W'(`ICACHE_WORDS - 1));

    always_ff @(posedge clk) begin
        if (!rstn) begin
            credit_cnt <= `ICACHE_CREDIT_W'(`ICACHE_MEM_CREDITS);
            pending    <= 1'b0;
            block_q    <= 1'b0;
            beat_cnt   <= '0;
            done_q     <= 1'b0;
        end else begin
            // spend on send, refund on each credit pulse
            credit_cnt <= credit_cnt - `ICACHE_CREDIT_W'(send)
                          + `ICACHE_CREDIT_W'(mem_credit);
            if (fetch_start) begin
                pending  <= 1'b1;
                block_q  <= fetch_block;
                beat_cnt <= '0;
            end else begin
                if (send) begin
                    pending <= 1'b0;
                end
                if (mem_rsp_valid) begin
                    beat_cnt <= last_beat ? '0 : beat_cnt + 1'b1;
                end
            end
            done_q <= mem_rsp_valid && last_beat;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_start) begin
            req_addr_q <= aligned;
        end
        // beats shift in from the top, word 0 ends up lowest
        if (mem_rsp_valid) begin
            line_buf <= {mem_rsp_data, line_buf[`ICACHE_LINE_W-1:`ICACHE_DATA_W]};
        end
    end

    assign fetch_done = done_q;
    // latest beat, the word of an uncached read
    assign fetch_word = line_buf[`ICACHE_LINE_W-1 -: `ICACHE_DATA_W];
    assign line_data  = line_buf;

endmodule

//--- hw/icache_store.sv
`timescale 1ns/100ps
`include "icache_macros.svh"

module icache_store (
    input  logic                       clk,
    input  logic                       rstn,
    input  icache_pkg::icache_addr_t   rd_addr,
    input  logic                       fill_en,
    input  logic [`ICACHE_LINE_W-1:0]  line_data,
    input  logic                       inv_en,
    input  logic                       inv_clear_tag,
    input  logic                       hit_check,
    output logic                       hit,
    output logic [`ICACHE_DATA_W-1:0]  rd_word
);
    import icache_pkg::*;

    logic [`ICACHE_LINES-1:0]  valid_bits;
    logic [`ICACHE_TAG_W-1:0]  tag_mem [`ICACHE_LINES];
    logic [`ICACHE_LINE_W-1:0] data_mem [`ICACHE_LINES];

    // registered read side
    icache_addr_t              addr_q;
    logic                      valid_q;
    logic [`ICACHE_TAG_W-1:0]  tag_q;
    logic [`ICACHE_LINE_W-1:0] line_q;

    logic [`ICACHE_INDEX_W-1:0] rd_idx;
    logic [`ICACHE_INDEX_W-1:0] wr_idx;
    logic                       same_idx;
    logic                       clear_ok;

    assign rd_idx = rd_addr.lookup.index;
    // writes always go to the line of the last read
    assign wr_idx   = addr_q.lookup.index;
    assign same_idx = (rd_idx == wr_idx);

    assign hit = valid_q && (tag_q == addr_q.lookup.tag);

    // hit invalidate needs the tag match, index invalidate does not
    assign clear_ok = inv_en && (!hit_check || hit);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_bits <= '0;
        end else if (fill_en) begin
            valid_bits[wr_idx] <= 1'b1;
        end else if (clear_ok) begin
            valid_bits[wr_idx] <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            tag_mem[wr_idx] <= addr_q.lookup.tag;
        end else if (clear_ok && inv_clear_tag) begin
            // init also wipes the tag
            tag_mem[wr_idx] <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (fill_en) begin
            data_mem[wr_idx] <= line_data;
        end
    end

    // valid read, forwarded when the same line is written this cycle
    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q <= 1'b0;
        end else if (same_idx && fill_en) begin
            valid_q <= 1'b1;
        end else if (same_idx && clear_ok) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid_bits[rd_idx];
        end
    end

    // tag and data read with the same forwarding
    always_ff @(posedge clk) begin
        addr_q <= rd_addr;
        if (same_idx && fill_en) begin
            tag_q  <= addr_q.lookup.tag;
            line_q <= line_data;
        end else begin
            tag_q  <= (same_idx && clear_ok && inv_clear_tag) ? '0 : tag_mem[rd_idx];
            line_q <= data_mem[rd_idx];
        end
    end

    // word select from the registered address
    assign rd_word = line_q[addr_q.lookup.woff * `ICACHE_DATA_W +: `ICACHE_DATA_W];

endmodule

//--- hw/icache_pkg.sv
`include "icache_macros.svh"

package icache_pkg;

    // operations issued by the cpu
    typedef enum logic [2:0] {
        op_none      = 3'd0,
        op_load      = 3'd1,
        op_init      = 3'd2,
        op_hit_inv   = 3'd3,
        op_index_inv = 3'd4
    } icache_op_t;

    // controller states
    typedef enum logic [3:0] {
        st_idle,
        st_lookup,
        st_req_word,
        st_word_wait,
        st_req_block,
        st_block_wait,
        st_fill,
        st_hit_inv,
        st_index_wv
    } icache_state_t;

    // one address word, two decodings
    typedef union packed {
        // lookup view for the arrays
        struct packed {
            logic [`ICACHE_TAG_W-1:0]   tag;
            logic [`ICACHE_INDEX_W-1:0] index;
            logic [`ICACHE_WOFF_W-1:0]  woff;
            logic [`ICACHE_ADDR_W-`ICACHE_TAG_W-`ICACHE_INDEX_W-`ICACHE_WOFF_W-1:0] boff;
        } lookup;
        // refill view, line address plus offset inside the line
        struct packed {
            logic [`ICACHE_TAG_W+`ICACHE_INDEX_W-1:0]               line;
            logic [`ICACHE_ADDR_W-`ICACHE_TAG_W-`ICACHE_INDEX_W-1:0] off;
        } refill;
    } icache_addr_t;

endpackage

//--- include/icache_macros.svh
`ifndef ICACHE_MACROS_SVH
`define ICACHE_MACROS_SVH

// address and instruction word, both one 32-bit word
`define ICACHE_ADDR_W 32
`define ICACHE_DATA_W 32

// direct mapped, 64 lines
`define ICACHE_LINES 64
`define ICACHE_INDEX_W 6

// 8 words per line, word select inside a line
`define ICACHE_WORDS 8
`define ICACHE_WOFF_W 3

// tag is what is left above index, word select and byte offset
`define ICACHE_TAG_W 21

// one full line as moved by a block refill
`define ICACHE_LINE_W (`ICACHE_WORDS * `ICACHE_DATA_W)

// credits granted by memory after reset
`define ICACHE_MEM_CREDITS 2

// credit counter, wide enough for the grant
`define ICACHE_CREDIT_W 2

`endif
